//--- hdl/wb_pkg.sv
package wb_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	localparam int data_width = 32;
	localparam int tag_width = 4;
	localparam int op_width = 3;
	localparam int imm_width = 16;

	//////////////////////////////////////////////////////////////////////
	// lanes
	//////////////////////////////////////////////////////////////////////

	localparam int n_lanes = 3;
	localparam int lane_id_width = 2;

	// fixed latency of each lane, in cycles
	localparam int lane_latency [n_lanes] = '{1, 3, 5};

	// depth of the writeback reservation register
	localparam int max_latency = 5;

	//////////////////////////////////////////////////////////////////////
	// operations
	//////////////////////////////////////////////////////////////////////

	localparam logic [op_width-1:0] op_add = 3'd0;
	localparam logic [op_width-1:0] op_sub = 3'd1;
	localparam logic [op_width-1:0] op_and = 3'd2;
	localparam logic [op_width-1:0] op_xor = 3'd3;
	// low half of the product
	localparam logic [op_width-1:0] op_mul = 3'd4;

	//////////////////////////////////////////////////////////////////////
	// instruction word
	//////////////////////////////////////////////////////////////////////

	// form bit 0 takes the second operand from the issue port,
	// form bit 1 takes it from the immediate
	typedef union packed {
		struct packed {
			logic form;
			logic [op_width-1:0] op;
			logic [lane_id_width-1:0] lane;
			logic [tag_width-1:0] tag;
			logic [21:0] rsvd;
		} r_form;
		struct packed {
			logic form;
			logic [op_width-1:0] op;
			logic [lane_id_width-1:0] lane;
			logic [tag_width-1:0] tag;
			logic [5:0] rsvd;
			logic signed [imm_width-1:0] imm;
		} i_form;
	} instr_t;

endpackage

//--- hdl/issue_decoder.sv
module issue_decoder (
	input logic issue_valid,
	input wb_pkg::instr_t issue_inst,
	input logic [wb_pkg::data_width-1:0] issue_a,
	input logic [wb_pkg::data_width-1:0] issue_b,
	input logic [wb_pkg::n_lanes-1:0] slot_free,
	output logic issue_ready,
	output logic [wb_pkg::n_lanes-1:0] lane_start,
	output logic [wb_pkg::op_width-1:0] lane_op,
	output logic [wb_pkg::data_width-1:0] lane_a,
	output logic [wb_pkg::data_width-1:0] lane_b,
	output logic [wb_pkg::tag_width-1:0] lane_tag
);

	logic is_imm;
	logic [wb_pkg::lane_id_width-1:0] lane;
	logic lane_legal;
	logic signed [wb_pkg::imm_width-1:0] imm;
	logic [wb_pkg::data_width-1:0] imm_ext;
	logic accept;

	//////////////////////////////////////////////////////////////////////
	// fields
	//////////////////////////////////////////////////////////////////////

	// fields common to both forms
	assign is_imm = issue_inst.r_form.form;
	assign lane = issue_inst.r_form.lane;
	assign lane_op = issue_inst.r_form.op;
	assign lane_tag = issue_inst.r_form.tag;

	assign imm = issue_inst.i_form.imm;
	assign imm_ext = {{(wb_pkg::data_width - wb_pkg::imm_width){imm[wb_pkg::imm_width-1]}}, imm};

	assign lane_a = issue_a;
	assign lane_b = is_imm ? imm_ext : issue_b;

	//////////////////////////////////////////////////////////////////////
	// handshake and steering
	//////////////////////////////////////////////////////////////////////

	assign lane_legal = lane < wb_pkg::n_lanes;

	// a missing lane matches no slot and is never ready
	always_comb begin
		issue_ready = 1'b0;
		for (int l = 0; l < wb_pkg::n_lanes; l++) begin
			if (lane == l) begin
				issue_ready = slot_free[l];
			end
		end
	end

	assign accept = issue_valid && issue_ready;

	always_comb begin
		lane_start = '0;
		for (int l = 0; l < wb_pkg::n_lanes; l++) begin
			lane_start[l] = accept && (lane == l);
		end
	end

	// an upstream word naming a missing lane would stall forever
	no_missing_lane: assert final (issue_valid !== 1'b1 || lane_legal)
	else $error("issue names lane %0d, which does not exist", lane);

endmodule

//--- hdl/exec_lane.sv
module exec_lane #(
	parameter int latency = 1
) (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic start,
	input logic [wb_pkg::op_width-1:0] op,
	input logic [wb_pkg::data_width-1:0] a,
	input logic [wb_pkg::data_width-1:0] b,
	input logic [wb_pkg::tag_width-1:0] tag,
	output logic res_valid,
	output logic [wb_pkg::tag_width-1:0] res_tag,
	output logic [wb_pkg::data_width-1:0] res_data
);

	logic [wb_pkg::data_width-1:0] alu_out;
	logic [latency-1:0] stage_valid;
	logic [wb_pkg::tag_width-1:0] stage_tag [latency];
	logic [wb_pkg::data_width-1:0] stage_data [latency];

	//////////////////////////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (op)
			wb_pkg::op_add: alu_out = a + b;
			wb_pkg::op_sub: alu_out = a - b;
			wb_pkg::op_and: alu_out = a & b;
			wb_pkg::op_xor: alu_out = a ^ b;
			wb_pkg::op_mul: alu_out = a * b;
			default: alu_out = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// pipeline
	//////////////////////////////////////////////////////////////////////

	// one item may sit in every stage
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			stage_valid <= '0;
		end else begin
			stage_valid[0] <= start;
			for (int i = 1; i < latency; i++) begin
				stage_valid[i] <= stage_valid[i-1];
			end
		end
	end

	// result computed in the first stage, then only carried
	always_ff @(posedge clk) begin
		stage_tag[0] <= tag;
		stage_data[0] <= alu_out;
		for (int i = 1; i < latency; i++) begin
			stage_tag[i] <= stage_tag[i-1];
			stage_data[i] <= stage_data[i-1];
		end
	end

	assign res_valid = stage_valid[latency-1];
	assign res_tag = stage_tag[latency-1];
	assign res_data = stage_data[latency-1];

	// the arbiter reserves its slot on this exact delay
	fixed_latency: assert property (
		@(posedge clk) disable iff (reset || flush)
		start |-> ##latency res_valid
	) else $error("lane result did not arrive %0d cycles after start", latency);

endmodule

//--- hdl/result_bus_arbiter.sv
module result_bus_arbiter (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic [wb_pkg::n_lanes-1:0] lane_start,
	input logic [wb_pkg::n_lanes-1:0] res_valid,
	input logic [wb_pkg::tag_width-1:0] res_tag [wb_pkg::n_lanes],
	input logic [wb_pkg::data_width-1:0] res_data [wb_pkg::n_lanes],
	output logic [wb_pkg::n_lanes-1:0] slot_free,
	output logic cdb_valid,
	output logic [wb_pkg::tag_width-1:0] cdb_tag,
	output logic [wb_pkg::data_width-1:0] cdb_data
);

	// slot 0 is the cycle currently on the bus
	logic [wb_pkg::max_latency-1:0] slot_valid;
	logic [wb_pkg::lane_id_width-1:0] slot_lane [wb_pkg::max_latency];
	logic [wb_pkg::lane_id_width-1:0] sel;

	//////////////////////////////////////////////////////////////////////
	// reservation register
	//////////////////////////////////////////////////////////////////////

	// shift toward slot 0, then drop the new lane at its latency
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			slot_valid <= '0;
		end else begin
			slot_valid <= slot_valid >> 1;
			for (int l = 0; l < wb_pkg::n_lanes; l++) begin
				if (lane_start[l]) begin
					slot_valid[wb_pkg::lane_latency[l]-1] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < wb_pkg::max_latency - 1; i++) begin
			slot_lane[i] <= slot_lane[i+1];
		end
		for (int l = 0; l < wb_pkg::n_lanes; l++) begin
			if (lane_start[l]) begin
				slot_lane[wb_pkg::lane_latency[l]-1] <= wb_pkg::lane_id_width'(l);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// issue permission
	//////////////////////////////////////////////////////////////////////

	// slot index is checked before the shift, hence latency and not latency-1
	for (genvar l = 0; l < wb_pkg::n_lanes; l++) begin : g_free
		if (wb_pkg::lane_latency[l] < wb_pkg::max_latency) begin : g_shared
			assign slot_free[l] = !flush && !slot_valid[wb_pkg::lane_latency[l]];
		end else begin : g_top
			// nothing can sit above the deepest slot
			assign slot_free[l] = !flush;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus
	//////////////////////////////////////////////////////////////////////

	assign sel = slot_lane[0];
	assign cdb_valid = slot_valid[0] && res_valid[sel];
	assign cdb_tag = res_tag[sel];
	assign cdb_data = res_data[sel];

	// a lane result with no slot, or a slot with no result, would be lost
	for (genvar l = 0; l < wb_pkg::n_lanes; l++) begin : g_check
		slot_matches_lane: assert property (
			@(posedge clk) disable iff (reset)
			res_valid[l] == (slot_valid[0] && slot_lane[0] == l)
		) else $error("lane %0d result out of step with its reserved slot", l);
	end

endmodule

//--- hdl/writeback_core.sv
module writeback_core (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic issue_valid,
	output logic issue_ready,
	input wb_pkg::instr_t issue_inst,
	input logic [wb_pkg::data_width-1:0] issue_a,
	input logic [wb_pkg::data_width-1:0] issue_b,
	output logic cdb_valid,
	output logic [wb_pkg::tag_width-1:0] cdb_tag,
	output logic [wb_pkg::data_width-1:0] cdb_data
);

	logic [wb_pkg::n_lanes-1:0] slot_free;
	logic [wb_pkg::n_lanes-1:0] lane_start;
	logic [wb_pkg::op_width-1:0] lane_op;
	logic [wb_pkg::data_width-1:0] lane_a;
	logic [wb_pkg::data_width-1:0] lane_b;
	logic [wb_pkg::tag_width-1:0] lane_tag;

	logic [wb_pkg::n_lanes-1:0] res_valid;
	logic [wb_pkg::tag_width-1:0] res_tag [wb_pkg::n_lanes];
	logic [wb_pkg::data_width-1:0] res_data [wb_pkg::n_lanes];

	issue_decoder issue_decoder (
		.issue_valid,
		.issue_inst,
		.issue_a,
		.issue_b,
		.slot_free,
		.issue_ready,
		.lane_start,
		.lane_op,
		.lane_a,
		.lane_b,
		.lane_tag
	);

	// lanes share operands, only start picks one
	for (genvar l = 0; l < wb_pkg::n_lanes; l++) begin : g_lane
		exec_lane #(
			.latency(wb_pkg::lane_latency[l])
		) exec_lane (
			.clk,
			.reset,
			.flush,
			.start(lane_start[l]),
			.op(lane_op),
			.a(lane_a),
			.b(lane_b),
			.tag(lane_tag),
			.res_valid(res_valid[l]),
			.res_tag(res_tag[l]),
			.res_data(res_data[l])
		);
	end

	result_bus_arbiter result_bus_arbiter (
		.clk,
		.reset,
		.flush,
		.lane_start,
		.res_valid,
		.res_tag,
		.res_data,
		.slot_free,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

endmodule

//--- verif/stimulus_table.svh
`ifndef stimulus_table_svh
`define stimulus_table_svh

// columns: form, op, lane, tag, immediate, a, b, expected result
// r-form rows carry junk in the immediate bits, which the DUT must ignore
localparam int n_stim = 14;

localparam logic [127:0] stim_table [n_stim] = '{
	stim_entry(1'b0, wb_pkg::op_add, 2'd0, 4'h1, 16'h1234,
		32'h0000_0010, 32'h0000_0005, 32'h0000_0015),
	stim_entry(1'b0, wb_pkg::op_sub, 2'd1, 4'h2, 16'h0000,
		32'h0000_0005, 32'h0000_0007, 32'hffff_fffe),
	stim_entry(1'b0, wb_pkg::op_and, 2'd2, 4'h3, 16'hffff,
		32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000),
	stim_entry(1'b0, wb_pkg::op_xor, 2'd0, 4'h4, 16'h0000,
		32'haaaa_5555, 32'hffff_0000, 32'h5555_5555),
	stim_entry(1'b0, wb_pkg::op_mul, 2'd1, 4'h5, 16'h8000,
		32'h0001_0001, 32'h0001_0001, 32'h0002_0001),
	stim_entry(1'b0, wb_pkg::op_mul, 2'd2, 4'h6, 16'h0000,
		32'hffff_ffff, 32'h0000_0007, 32'hffff_fff9),
	// immediate forms, b is ignored
	stim_entry(1'b1, wb_pkg::op_add, 2'd0, 4'h7, 16'hfffd,
		32'h0000_000a, 32'hdead_beef, 32'h0000_0007),
	stim_entry(1'b1, wb_pkg::op_sub, 2'd1, 4'h8, 16'h0064,
		32'h0000_1000, 32'hdead_beef, 32'h0000_0f9c),
	stim_entry(1'b1, wb_pkg::op_and, 2'd2, 4'h9, 16'h8000,
		32'h1234_5678, 32'h0000_0000, 32'h1234_0000),
	stim_entry(1'b1, wb_pkg::op_xor, 2'd1, 4'ha, 16'h7fff,
		32'h0000_0000, 32'hffff_ffff, 32'h0000_7fff),
	stim_entry(1'b1, wb_pkg::op_mul, 2'd0, 4'hb, 16'hfffe,
		32'h0000_0003, 32'h0000_0001, 32'hffff_fffa),
	stim_entry(1'b0, wb_pkg::op_add, 2'd2, 4'hc, 16'h0000,
		32'hffff_ffff, 32'h0000_0001, 32'h0000_0000),
	stim_entry(1'b1, wb_pkg::op_add, 2'd2, 4'hd, 16'hffff,
		32'h0000_0000, 32'h0000_0005, 32'hffff_ffff),
	stim_entry(1'b0, wb_pkg::op_xor, 2'd1, 4'he, 16'h0000,
		32'h1234_5678, 32'h1234_5678, 32'h0000_0000)
};

`endif

//--- verif/tb_writeback_core.sv
module tb_writeback_core;

	localparam int random_count = 200;

	logic clk;
	logic reset;
	logic flush;
	logic issue_valid;
	logic issue_ready;
	wb_pkg::instr_t issue_inst;
	logic [wb_pkg::data_width-1:0] issue_a;
	logic [wb_pkg::data_width-1:0] issue_b;
	logic cdb_valid;
	logic [wb_pkg::tag_width-1:0] cdb_tag;
	logic [wb_pkg::data_width-1:0] cdb_data;

	// reference slots, index 0 is the cycle on the bus
	logic model_valid [wb_pkg::max_latency];
	logic [wb_pkg::tag_width-1:0] model_tag [wb_pkg::max_latency];
	logic [wb_pkg::data_width-1:0] model_data [wb_pkg::max_latency];
	logic [31:0] rng_state;
	int bus_count;
	int accepted_count;
	logic bus_seen;
	logic [3:0] bus_tag_seen;
	logic [31:0] bus_data_seen;

	function automatic logic [31:0] make_inst(input logic form, input logic [2:0] op,
			input logic [1:0] lane, input logic [3:0] tag, input logic [15:0] imm);
		return {form, op, lane, tag, 6'd0, imm};
	endfunction

	function automatic logic [127:0] stim_entry(input logic form, input logic [2:0] op,
			input logic [1:0] lane, input logic [3:0] tag, input logic [15:0] imm,
			input logic [31:0] a, input logic [31:0] b, input logic [31:0] expected);
		return {make_inst(form, op, lane, tag, imm), a, b, expected};
	endfunction

	`include "stimulus_table.svh"

	// room for every item to take the longest path through the lanes
	localparam longint watchdog_time =
		longint'(n_stim + random_count) * (wb_pkg::max_latency + 4) * 40;

	writeback_core dut (.*);

	always #20 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// checking and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			fail_run($sformatf("FAILED at time %0t: %s, got %0h, expected %0h",
				$time, what, actual, expected));
		end
	endtask

	function automatic logic [15:0] random16();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[31:16];
	endfunction

	function automatic logic [31:0] expected_alu(input logic [2:0] op,
			input logic [31:0] a, input logic [31:0] b);
		case (op)
			wb_pkg::op_add: return a + b;
			wb_pkg::op_sub: return a - b;
			wb_pkg::op_and: return a & b;
			wb_pkg::op_xor: return a ^ b;
			wb_pkg::op_mul: return a * b;
			default: return 32'd0;
		endcase
	endfunction

	// the slot that lands on latency-1 after the next shift must be empty
	function automatic logic model_ready(input logic [31:0] inst, input logic flush_in);
		int lat;
		if (flush_in || inst[27:26] >= wb_pkg::n_lanes) begin
			return 1'b0;
		end
		lat = wb_pkg::lane_latency[inst[27:26]];
		if (lat >= wb_pkg::max_latency) begin
			return 1'b1;
		end
		return !model_valid[lat];
	endfunction

	task automatic model_advance(input logic flush_in, input logic accepted,
			input logic [31:0] inst, input logic [31:0] a, input logic [31:0] b);
		int lat;
		logic [31:0] operand;
		for (int i = 0; i < wb_pkg::max_latency - 1; i++) begin
			model_valid[i] = model_valid[i+1] && !flush_in;
			model_tag[i] = model_tag[i+1];
			model_data[i] = model_data[i+1];
		end
		model_valid[wb_pkg::max_latency-1] = 1'b0;
		if (accepted && !flush_in) begin
			lat = wb_pkg::lane_latency[inst[27:26]];
			// immediate form sign-extends the low half
			operand = inst[31] ? {{16{inst[15]}}, inst[15:0]} : b;
			model_valid[lat-1] = 1'b1;
			model_tag[lat-1] = inst[25:22];
			model_data[lat-1] = expected_alu(inst[30:28], a, operand);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// drivers
	//////////////////////////////////////////////////////////////////////

	// entered and left 2 units after a rising edge
	task automatic run_cycle(input logic valid, input logic [31:0] inst,
			input logic [31:0] a, input logic [31:0] b, input logic flush_in,
			output logic accepted);
		issue_valid = valid;
		issue_inst = inst;
		issue_a = a;
		issue_b = b;
		flush = flush_in;
		@(negedge clk);
		check_equal(issue_ready, model_ready(inst, flush_in), "issue_ready");
		check_equal(cdb_valid, model_valid[0], "cdb_valid");
		if (model_valid[0]) begin
			check_equal(cdb_tag, model_tag[0], "cdb_tag");
			check_equal(cdb_data, model_data[0], "cdb_data");
		end
		bus_seen = cdb_valid;
		bus_tag_seen = cdb_tag;
		bus_data_seen = cdb_data;
		if (cdb_valid) begin
			bus_count++;
		end
		accepted = valid && issue_ready;
		@(posedge clk);
		model_advance(flush_in, accepted, inst, a, b);
		#2;
	endtask

	task automatic issue_until_accepted(input logic [31:0] inst, input logic [31:0] a,
			input logic [31:0] b);
		logic acc;
		acc = 1'b0;
		while (!acc) begin
			run_cycle(1'b1, inst, a, b, 1'b0, acc);
		end
		accepted_count++;
	endtask

	task automatic present_entry(input int i, input logic flush_in, output logic acc);
		run_cycle(1'b1, stim_table[i][127:96], stim_table[i][95:64], stim_table[i][63:32],
			flush_in, acc);
	endtask

	task automatic idle_cycles(input int n);
		logic acc;
		repeat (n) begin
			run_cycle(1'b0, 32'd0, 32'd0, 32'd0, 1'b0, acc);
		end
	endtask

	initial begin
		#(watchdog_time);
		fail_run($sformatf("watchdog expired at time %0t, the run hung", $time));
	end

	initial begin
		logic acc;
		logic [127:0] row;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [15:0] r;
		int lat;
		int count_before;
		int accepted_before;

		clk = 1'b0;
		reset = 1'b1;
		flush = 1'b0;
		issue_valid = 1'b0;
		issue_inst = '0;
		issue_a = '0;
		issue_b = '0;
		rng_state = 32'd81537;
		bus_count = 0;
		accepted_count = 0;
		for (int i = 0; i < wb_pkg::max_latency; i++) begin
			model_valid[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#2;
		check_equal(cdb_valid, 1'b0, "cdb_valid after reset");
		check_equal(issue_ready, 1'b1, "issue_ready after reset");
		reset = 1'b0;

		// each entry alone, result exactly one lane latency later
		for (int i = 0; i < n_stim; i++) begin
			row = stim_table[i];
			inst = row[127:96];
			issue_until_accepted(inst, row[95:64], row[63:32]);
			lat = wb_pkg::lane_latency[inst[27:26]];
			for (int c = 1; c <= wb_pkg::max_latency + 2; c++) begin
				run_cycle(1'b0, inst, 32'd0, 32'd0, 1'b0, acc);
				check_equal(bus_seen, c == lat,
					$sformatf("entry %0d bus valid in cycle %0d", i, c));
				if (c == lat) begin
					check_equal(bus_tag_seen, inst[25:22], $sformatf("entry %0d tag", i));
					check_equal(bus_data_seen, row[31:0], $sformatf("entry %0d result", i));
				end
			end
		end

		// lane 2 then lane 1 two cycles later want the same slot
		count_before = bus_count;
		accepted_before = accepted_count;
		present_entry(2, 1'b0, acc);
		check_equal(acc, 1'b1, "lane 2 issue accepted");
		idle_cycles(1);
		present_entry(1, 1'b0, acc);
		check_equal(acc, 1'b0, "lane 1 held off by the lane 2 slot");
		present_entry(1, 1'b0, acc);
		check_equal(acc, 1'b1, "lane 1 issue once the slot moved on");
		accepted_count += 2;
		for (int i = 0; i < n_stim; i++) begin
			row = stim_table[i];
			issue_until_accepted(row[127:96], row[95:64], row[63:32]);
		end
		idle_cycles(wb_pkg::max_latency + 1);
		check_equal(bus_count - count_before, accepted_count - accepted_before,
			"bus results per accepted issue, mixed lanes");

		// flush with three results in flight
		count_before = bus_count;
		present_entry(2, 1'b0, acc);
		check_equal(acc, 1'b1, "first issue before flush");
		present_entry(1, 1'b0, acc);
		check_equal(acc, 1'b1, "second issue before flush");
		present_entry(5, 1'b0, acc);
		check_equal(acc, 1'b1, "third issue before flush");
		present_entry(4, 1'b1, acc);
		check_equal(acc, 1'b0, "issue during flush");
		idle_cycles(wb_pkg::max_latency + 1);
		check_equal(bus_count, count_before, "bus results after flush");
		accepted_before = accepted_count;
		for (int i = 0; i < 4; i++) begin
			row = stim_table[i];
			issue_until_accepted(row[127:96], row[95:64], row[63:32]);
		end
		idle_cycles(wb_pkg::max_latency + 1);
		check_equal(bus_count - count_before, accepted_count - accepted_before,
			"bus results per accepted issue after flush");

		// random traffic, each word held until the model allows it
		count_before = bus_count;
		accepted_before = accepted_count;
		for (int n = 0; n < random_count; n++) begin
			r = random16();
			inst = make_inst(r[15], 3'(random16() % 5), 2'(random16() % 3), r[3:0],
				random16());
			a = {random16(), random16()};
			b = {random16(), random16()};
			if (r[9:8] == 2'd0) begin
				run_cycle(1'b0, inst, a, b, 1'b0, acc);
			end
			issue_until_accepted(inst, a, b);
		end
		idle_cycles(wb_pkg::max_latency + 1);
		check_equal(bus_count - count_before, accepted_count - accepted_before,
			"bus results per accepted issue, random traffic");

		$display("** PASS **");
		$finish;
	end

endmodule

//--- all.f
+incdir+verif
hdl/wb_pkg.sv
hdl/issue_decoder.sv
hdl/exec_lane.sv
hdl/result_bus_arbiter.sv
hdl/writeback_core.sv
verif/tb_writeback_core.sv

//--- Bender.yml
package:
  name: writeback_core

sources:
  - hdl/wb_pkg.sv
  - hdl/issue_decoder.sv
  - hdl/exec_lane.sv
  - hdl/result_bus_arbiter.sv
  - hdl/writeback_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_writeback_core.sv
